// File: hw/ccipTracePkg.sv
// Trace recorder shared widths, channel and request encodings, and trace record layout
`default_nettype none

package ccipTracePkg;

   //////////////////////////////////////////////////////////////////////
   // Widths and sizes
   //////////////////////////////////////////////////////////////////////

   // Payload on write request and read response
   localparam int DATA_W = 64;
   localparam int ADDR_W = 32;
   localparam int MDATA_W = 16;
   localparam int TYPE_W = 4;
   // Free-running cycle stamp
   localparam int TS_W = 24;
   // Payload digest, upper half XOR lower half
   localparam int DIGEST_W = 32;

   // Shared trace memory
   localparam int TRACE_DEPTH = 16;
   localparam int IDX_W = $clog2(TRACE_DEPTH);
   // Occupancy must reach TRACE_DEPTH itself
   localparam int COUNT_W = IDX_W + 1;
   // Running totals for records and drops
   localparam int TOTAL_W = 32;

   // Per-monitor queue
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   // Monitored channels, kept a power of two for the arbiter wrap
   localparam int NUM_CHAN = 4;
   localparam int CHAN_W = $clog2(NUM_CHAN);

   //////////////////////////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      CH_RDREQ = 2'd0,
      CH_WRREQ = 2'd1,
      CH_RDRSP = 2'd2,
      CH_WRRSP = 2'd3
   } chanT;

   // Virtual channel select, same order as the cache port header
   typedef enum logic [1:0] {
      VC_VA  = 2'b00,
      VC_VL0 = 2'b01,
      VC_VH0 = 2'b10,
      VC_VH1 = 2'b11
   } vcT;

   // Request types
   localparam logic [TYPE_W-1:0] REQ_RDLINE_S = 4'h4;
   localparam logic [TYPE_W-1:0] REQ_RDLINE_I = 4'h5;
   localparam logic [TYPE_W-1:0] REQ_WRLINE_I = 4'h1;
   localparam logic [TYPE_W-1:0] REQ_WRLINE_M = 4'h2;
   // Response types
   localparam logic [TYPE_W-1:0] RSP_RD = 4'h0;
   localparam logic [TYPE_W-1:0] RSP_WR = 4'h1;

   // One trace record, 112 bits, timestamp in the top bits
   typedef struct packed {
      logic [TS_W-1:0]     timestamp;
      chanT                chan;
      vcT                  vc;
      logic [TYPE_W-1:0]   reqType;
      logic [MDATA_W-1:0]  mdata;
      logic [ADDR_W-1:0]   addr;
      logic [DIGEST_W-1:0] digest;
   } traceRecT;

endpackage

`default_nettype wire

// File: hw/chanMonitor.sv
// Channel monitor that formats each enabled beat into a trace record and queues it
`timescale 1ns/10ps
`default_nettype none

module chanMonitor #(
   parameter ccipTracePkg::chanT chanId = ccipTracePkg::CH_RDREQ
) (
   input  wire logic                               clk,
   input  wire logic                               rstN,
   input  wire logic                               enable,
   input  wire logic                               valid,
   input  wire ccipTracePkg::vcT                   vc,
   input  wire logic [ccipTracePkg::TYPE_W-1:0]    reqType,
   input  wire logic [ccipTracePkg::MDATA_W-1:0]   mdata,
   input  wire logic [ccipTracePkg::ADDR_W-1:0]    addr,
   input  wire logic [ccipTracePkg::DATA_W-1:0]    data,
   input  wire logic [ccipTracePkg::TS_W-1:0]      now,
   input  wire logic                               grant,
   output logic                                    pending,
   output ccipTracePkg::traceRecT                  headRec,
   output logic                                    dropPulse
);

   import ccipTracePkg::*;

   traceRecT              beatRec;
   traceRecT              fifoMem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wrPtr;
   logic [FIFO_PTR_W-1:0] rdPtr;
   logic [FIFO_CNT_W-1:0] fifoCnt;
   logic                  beat;
   logic                  full;
   logic                  push;
   logic                  pop;

   //////////////////////////////////////////////////////////////////////
   // Record formatting
   //////////////////////////////////////////////////////////////////////

   // Stamp taken at the sampling edge
   always_comb begin
      beatRec.timestamp = now;
      beatRec.chan = chanId;
      beatRec.vc = vc;
      beatRec.reqType = reqType;
      beatRec.mdata = mdata;
      beatRec.addr = addr;
      // Fold the payload halves
      beatRec.digest = data[DATA_W-1:DIGEST_W] ^ data[DIGEST_W-1:0];
   end

   //////////////////////////////////////////////////////////////////////
   // Queue control
   //////////////////////////////////////////////////////////////////////

   assign beat = enable && valid;
   assign full = (fifoCnt == FIFO_CNT_W'(FIFO_DEPTH));
   // Arbiter only grants a pending monitor
   assign pop = grant && pending;
   // A full queue still accepts when its head leaves this edge
   assign push = beat && (!full || pop);

   assign pending = (fifoCnt != '0);
   assign headRec = fifoMem[rdPtr];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         fifoCnt <= '0;
         dropPulse <= 1'b0;
      end else begin
         if (push) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         case ({push, pop})
            2'b10: fifoCnt <= fifoCnt + 1'b1;
            2'b01: fifoCnt <= fifoCnt - 1'b1;
            default: fifoCnt <= fifoCnt;
         endcase
         // One pulse per lost beat
         dropPulse <= beat && !push;
      end
   end

   // Queue storage
   always_ff @(posedge clk) begin
      if (push) begin
         fifoMem[wrPtr] <= beatRec;
      end
   end

endmodule

`default_nettype wire

// File: hw/traceArbiter.sv
// Round-robin arbiter moving one monitor head record per cycle onto the trace write bus
`timescale 1ns/10ps
`default_nettype none

module traceArbiter (
   input  wire logic                                clk,
   input  wire logic                                rstN,
   input  wire logic [ccipTracePkg::NUM_CHAN-1:0]   pending,
   input  wire ccipTracePkg::traceRecT              headRec [ccipTracePkg::NUM_CHAN],
   output logic [ccipTracePkg::NUM_CHAN-1:0]        grant,
   output logic                                     wrEn,
   output ccipTracePkg::traceRecT                   wrRec
);

   import ccipTracePkg::*;

   logic [CHAN_W-1:0] lastWin;
   logic [CHAN_W-1:0] winIdx;
   logic [CHAN_W-1:0] cand;
   logic              anyWin;

   //////////////////////////////////////////////////////////////////////
   // Winner select
   //////////////////////////////////////////////////////////////////////

   // Scan starts one past the last winner, last winner checked last
   always_comb begin
      anyWin = 1'b0;
      winIdx = lastWin;
      cand = lastWin;
      for (int k = 1; k <= NUM_CHAN; k++) begin
         // Wraps modulo NUM_CHAN
         cand = lastWin + CHAN_W'(k);
         if (!anyWin && pending[cand]) begin
            anyWin = 1'b1;
            winIdx = cand;
         end
      end
   end

   // One-hot pop to the winning monitor
   always_comb begin
      grant = '0;
      if (anyWin) begin
         grant[winIdx] = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write bus
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         // Channel 0 gets first turn
         lastWin <= CHAN_W'(NUM_CHAN - 1);
         wrEn <= 1'b0;
      end else begin
         wrEn <= anyWin;
         if (anyWin) begin
            lastWin <= winIdx;
         end
      end
   end

   // Record is valid only with wrEn
   always_ff @(posedge clk) begin
      wrRec <= headRec[winIdx];
   end

endmodule

`default_nettype wire

// File: hw/traceBuffer.sv
// Circular trace memory with cycle timestamp, record and drop counters, and indexed readout
`timescale 1ns/10ps
`default_nettype none

module traceBuffer (
   input  wire logic                                clk,
   input  wire logic                                rstN,
   input  wire logic                                wrEn,
   input  wire ccipTracePkg::traceRecT              wrRec,
   input  wire logic [ccipTracePkg::NUM_CHAN-1:0]   dropPulse,
   input  wire logic [ccipTracePkg::IDX_W-1:0]      rdIdx,
   output logic [ccipTracePkg::TS_W-1:0]            now,
   output ccipTracePkg::traceRecT                   rdRec,
   output logic [ccipTracePkg::COUNT_W-1:0]         recCount,
   output logic [ccipTracePkg::TOTAL_W-1:0]         recTotal,
   output logic [ccipTracePkg::TOTAL_W-1:0]         dropTotal
);

   import ccipTracePkg::*;

   traceRecT          traceMem [TRACE_DEPTH];
   logic [IDX_W-1:0]  wrPtr;
   logic [IDX_W-1:0]  rdAddr;
   logic              wrapped;
   logic [CHAN_W:0]   dropSum;

   //////////////////////////////////////////////////////////////////////
   // Timestamp
   //////////////////////////////////////////////////////////////////////

   // Zero in the first cycle out of reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         now <= '0;
      end else begin
         now <= now + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write side and counters
   //////////////////////////////////////////////////////////////////////

   // Drops from all monitors in one cycle
   always_comb begin
      dropSum = '0;
      for (int c = 0; c < NUM_CHAN; c++) begin
         dropSum = dropSum + {{CHAN_W{1'b0}}, dropPulse[c]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wrPtr <= '0;
         recCount <= '0;
         recTotal <= '0;
         dropTotal <= '0;
      end else begin
         if (wrEn) begin
            wrPtr <= wrPtr + 1'b1;
            recTotal <= recTotal + 1'b1;
            // Saturate once full, oldest entries get overwritten
            if (!wrapped) begin
               recCount <= recCount + 1'b1;
            end
         end
         dropTotal <= dropTotal + TOTAL_W'(dropSum);
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         traceMem[wrPtr] <= wrRec;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Readout
   //////////////////////////////////////////////////////////////////////

   assign wrapped = (recCount == COUNT_W'(TRACE_DEPTH));
   // Index 0 is the oldest; after wrap that is the next slot to write
   assign rdAddr = wrapped ? (wrPtr + rdIdx) : rdIdx;

   // One cycle read latency
   always_ff @(posedge clk) begin
      rdRec <= traceMem[rdAddr];
   end

endmodule

`default_nettype wire

// File: hw/ccipTraceTop.sv
// Cache port trace recorder top with four channel monitors, arbiter and trace memory
`timescale 1ns/10ps
`default_nettype none

module ccipTraceTop (
   input  wire logic                               clk,
   input  wire logic                               rstN,
   input  wire logic                               enable,
   // Read request
   input  wire logic                               rdReqValid,
   input  wire ccipTracePkg::vcT                   rdReqVc,
   input  wire logic [ccipTracePkg::TYPE_W-1:0]    rdReqType,
   input  wire logic [ccipTracePkg::MDATA_W-1:0]   rdReqMdata,
   input  wire logic [ccipTracePkg::ADDR_W-1:0]    rdReqAddr,
   // Write request
   input  wire logic                               wrReqValid,
   input  wire ccipTracePkg::vcT                   wrReqVc,
   input  wire logic [ccipTracePkg::TYPE_W-1:0]    wrReqType,
   input  wire logic [ccipTracePkg::MDATA_W-1:0]   wrReqMdata,
   input  wire logic [ccipTracePkg::ADDR_W-1:0]    wrReqAddr,
   input  wire logic [ccipTracePkg::DATA_W-1:0]    wrReqData,
   // Read response
   input  wire logic                               rdRspValid,
   input  wire ccipTracePkg::vcT                   rdRspVc,
   input  wire logic [ccipTracePkg::TYPE_W-1:0]    rdRspType,
   input  wire logic [ccipTracePkg::MDATA_W-1:0]   rdRspMdata,
   input  wire logic [ccipTracePkg::DATA_W-1:0]    rdRspData,
   // Write response
   input  wire logic                               wrRspValid,
   input  wire ccipTracePkg::vcT                   wrRspVc,
   input  wire logic [ccipTracePkg::TYPE_W-1:0]    wrRspType,
   input  wire logic [ccipTracePkg::MDATA_W-1:0]   wrRspMdata,
   // Software readback
   input  wire logic [ccipTracePkg::IDX_W-1:0]     rdIdx,
   output ccipTracePkg::traceRecT                  rdRec,
   output logic [ccipTracePkg::COUNT_W-1:0]        recCount,
   output logic [ccipTracePkg::TOTAL_W-1:0]        recTotal,
   output logic [ccipTracePkg::TOTAL_W-1:0]        dropTotal
);

   import ccipTracePkg::*;

   logic [NUM_CHAN-1:0] pending;
   logic [NUM_CHAN-1:0] grant;
   logic [NUM_CHAN-1:0] dropPulse;
   traceRecT            headRec [NUM_CHAN];
   logic                wrEn;
   traceRecT            wrRec;
   logic [TS_W-1:0]     now;

   //////////////////////////////////////////////////////////////////////
   // Channel monitors, missing fields tied low
   //////////////////////////////////////////////////////////////////////

   chanMonitor #(.chanId(CH_RDREQ)) i_rdReqMon (
      .clk(clk), .rstN(rstN), .enable(enable), .valid(rdReqValid),
      .vc(rdReqVc), .reqType(rdReqType), .mdata(rdReqMdata), .addr(rdReqAddr),
      .data('0), .now(now), .grant(grant[CH_RDREQ]), .pending(pending[CH_RDREQ]),
      .headRec(headRec[CH_RDREQ]), .dropPulse(dropPulse[CH_RDREQ])
   );

   chanMonitor #(.chanId(CH_WRREQ)) i_wrReqMon (
      .clk(clk), .rstN(rstN), .enable(enable), .valid(wrReqValid),
      .vc(wrReqVc), .reqType(wrReqType), .mdata(wrReqMdata), .addr(wrReqAddr),
      .data(wrReqData), .now(now), .grant(grant[CH_WRREQ]), .pending(pending[CH_WRREQ]),
      .headRec(headRec[CH_WRREQ]), .dropPulse(dropPulse[CH_WRREQ])
   );

   // Responses carry no address
   chanMonitor #(.chanId(CH_RDRSP)) i_rdRspMon (
      .clk(clk), .rstN(rstN), .enable(enable), .valid(rdRspValid),
      .vc(rdRspVc), .reqType(rdRspType), .mdata(rdRspMdata), .addr('0),
      .data(rdRspData), .now(now), .grant(grant[CH_RDRSP]), .pending(pending[CH_RDRSP]),
      .headRec(headRec[CH_RDRSP]), .dropPulse(dropPulse[CH_RDRSP])
   );

   chanMonitor #(.chanId(CH_WRRSP)) i_wrRspMon (
      .clk(clk), .rstN(rstN), .enable(enable), .valid(wrRspValid),
      .vc(wrRspVc), .reqType(wrRspType), .mdata(wrRspMdata), .addr('0),
      .data('0), .now(now), .grant(grant[CH_WRRSP]), .pending(pending[CH_WRRSP]),
      .headRec(headRec[CH_WRRSP]), .dropPulse(dropPulse[CH_WRRSP])
   );

   //////////////////////////////////////////////////////////////////////
   // Arbitration and storage
   //////////////////////////////////////////////////////////////////////

   traceArbiter i_arbiter (
      .clk(clk), .rstN(rstN), .pending(pending), .headRec(headRec),
      .grant(grant), .wrEn(wrEn), .wrRec(wrRec)
   );

   traceBuffer i_buffer (
      .clk(clk), .rstN(rstN), .wrEn(wrEn), .wrRec(wrRec), .dropPulse(dropPulse),
      .rdIdx(rdIdx), .now(now), .rdRec(rdRec), .recCount(recCount),
      .recTotal(recTotal), .dropTotal(dropTotal)
   );

endmodule

`default_nettype wire

// File: bench/traceCheck.svh
// Reference record builder and typed compare tasks for the trace recorder testbench
`ifndef TRACE_CHECK_SVH
`define TRACE_CHECK_SVH

// Expected record of one beat sampled when the cycle count was ts
function automatic traceRecT expectRec(
   input chanT                ch,
   input vcT                  vc,
   input logic [TYPE_W-1:0]   reqType,
   input logic [MDATA_W-1:0]  mdata,
   input logic [ADDR_W-1:0]   addr,
   input logic [DATA_W-1:0]   data,
   input logic [TS_W-1:0]     ts
);
   traceRecT rec;
   rec.timestamp = ts;
   rec.chan = ch;
   rec.vc = vc;
   rec.reqType = reqType;
   rec.mdata = mdata;
   // Only requests carry an address
   rec.addr = (ch == CH_RDREQ || ch == CH_WRREQ) ? addr : '0;
   // Payload on write request and read response only
   if (ch == CH_WRREQ || ch == CH_RDRSP) begin
      rec.digest = data[DATA_W-1:DATA_W/2] ^ data[DATA_W/2-1:0];
   end else begin
      rec.digest = '0;
   end
   return rec;
endfunction

task automatic checkRec(input string name, input traceRecT got, input traceRecT want);
   if (got !== want) begin
      failRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
   end
endtask

task automatic checkCount(input string name, input logic [TOTAL_W-1:0] got,
                          input logic [TOTAL_W-1:0] want);
   if (got !== want) begin
      failRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
   end
endtask

task automatic checkChan(input string name, input chanT got, input chanT want);
   if (got !== want) begin
      failRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, want));
   end
endtask

`endif

// File: bench/ccipTraceTb.sv
// Testbench for the cache port trace recorder with reference model, readback and scoreboard
`timescale 1ns/10ps
`default_nettype none

module ccipTraceTb;

   import ccipTracePkg::*;

   localparam int CLK_PERIOD = 40;
   localparam logic [31:0] SEED = 32'h91ab3d03;
   // Worst case from last beat to its write or drop
   localparam int DRAIN_SLACK = FIFO_DEPTH * NUM_CHAN + 8;
   // All stimulus, then reset, drain and readouts for each of five tests
   localparam int STIM_CYCLES = 12 * 4 + 24 + 20 + 8 + 10 + 5;
   localparam int CYCLE_LIMIT = STIM_CYCLES + 5 * (4 + 2 * DRAIN_SLACK + 4 * (TRACE_DEPTH + 2));

   logic                clk = 1'b0;
   logic                rstN = 1'b0;
   logic                enable = 1'b1;
   logic                rdReqValid = 1'b0;
   vcT                  rdReqVc = VC_VA;
   logic [TYPE_W-1:0]   rdReqType = '0;
   logic [MDATA_W-1:0]  rdReqMdata = '0;
   logic [ADDR_W-1:0]   rdReqAddr = '0;
   logic                wrReqValid = 1'b0;
   vcT                  wrReqVc = VC_VA;
   logic [TYPE_W-1:0]   wrReqType = '0;
   logic [MDATA_W-1:0]  wrReqMdata = '0;
   logic [ADDR_W-1:0]   wrReqAddr = '0;
   logic [DATA_W-1:0]   wrReqData = '0;
   logic                rdRspValid = 1'b0;
   vcT                  rdRspVc = VC_VA;
   logic [TYPE_W-1:0]   rdRspType = '0;
   logic [MDATA_W-1:0]  rdRspMdata = '0;
   logic [DATA_W-1:0]   rdRspData = '0;
   logic                wrRspValid = 1'b0;
   vcT                  wrRspVc = VC_VA;
   logic [TYPE_W-1:0]   wrRspType = '0;
   logic [MDATA_W-1:0]  wrRspMdata = '0;
   logic [IDX_W-1:0]    rdIdx = '0;
   traceRecT            rdRec;
   logic [COUNT_W-1:0]  recCount;
   logic [TOTAL_W-1:0]  recTotal;
   logic [TOTAL_W-1:0]  dropTotal;

   // Model state, mirrors the DUT timestamp
   logic [TS_W-1:0]     tbCycle = '0;
   traceRecT            expQ [$];
   int                  cycleCount = 0;

   // Names match the DUT ports one for one
   ccipTraceTop i_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "run stopped at its first failure");
   endtask

   `include "traceCheck.svh"

   //////////////////////////////////////////////////////////////////////
   // Reference model, every enabled beat in sampling order
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!rstN) begin
         tbCycle <= '0;
         expQ.delete();
      end else begin
         tbCycle <= tbCycle + 1'b1;
         if (enable && rdReqValid) begin
            expQ.push_back(expectRec(CH_RDREQ, rdReqVc, rdReqType, rdReqMdata, rdReqAddr,
                                     '0, tbCycle));
         end
         if (enable && wrReqValid) begin
            expQ.push_back(expectRec(CH_WRREQ, wrReqVc, wrReqType, wrReqMdata, wrReqAddr,
                                     wrReqData, tbCycle));
         end
         if (enable && rdRspValid) begin
            expQ.push_back(expectRec(CH_RDRSP, rdRspVc, rdRspType, rdRspMdata, '0,
                                     rdRspData, tbCycle));
         end
         if (enable && wrRspValid) begin
            expQ.push_back(expectRec(CH_WRRSP, wrRspVc, wrRspType, wrRspMdata, '0,
                                     '0, tbCycle));
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == CYCLE_LIMIT) begin
         failRun("simulation ran past its cycle limit without finishing");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus and readout
   //////////////////////////////////////////////////////////////////////

   task automatic resetDut();
      @(posedge clk);
      rstN <= 1'b0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
   endtask

   // One bus cycle, mask bit per channel code, random fields
   task automatic issueCycle(input logic [NUM_CHAN-1:0] mask);
      @(posedge clk);
      rdReqValid <= mask[CH_RDREQ];
      rdReqVc <= vcT'($urandom_range(3));
      rdReqType <= ($urandom_range(1) == 0) ? REQ_RDLINE_S : REQ_RDLINE_I;
      rdReqMdata <= MDATA_W'($urandom);
      rdReqAddr <= $urandom;
      wrReqValid <= mask[CH_WRREQ];
      wrReqVc <= vcT'($urandom_range(3));
      wrReqType <= ($urandom_range(1) == 0) ? REQ_WRLINE_I : REQ_WRLINE_M;
      wrReqMdata <= MDATA_W'($urandom);
      wrReqAddr <= $urandom;
      wrReqData <= {$urandom, $urandom};
      rdRspValid <= mask[CH_RDRSP];
      rdRspVc <= vcT'($urandom_range(3));
      rdRspType <= RSP_RD;
      rdRspMdata <= MDATA_W'($urandom);
      rdRspData <= {$urandom, $urandom};
      wrRspValid <= mask[CH_WRRSP];
      wrRspVc <= vcT'($urandom_range(3));
      wrRspType <= RSP_WR;
      wrRspMdata <= MDATA_W'($urandom);
   endtask

   // Done once every issued beat is either written or dropped
   task automatic waitDrain();
      int waited;
      waited = 0;
      @(negedge clk);
      while (recTotal + dropTotal < TOTAL_W'(expQ.size())) begin
         if (waited == DRAIN_SLACK) begin
            failRun("trace pipeline did not drain within its slack");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic readIndex(input int idx, output traceRecT rec);
      @(posedge clk);
      rdIdx <= IDX_W'(idx);
      @(posedge clk);
      @(negedge clk);
      rec = rdRec;
   endtask

   // Oldest first; lossy skips overwritten or dropped beats of the channel
   task automatic readBack(input bit lossy);
      int rdPos [NUM_CHAN];
      int n;
      traceRecT got;
      chanT ch;
      n = int'(recCount);
      for (int c = 0; c < NUM_CHAN; c++) begin
         rdPos[c] = 0;
      end
      for (int i = 0; i < n; i++) begin
         readIndex(i, got);
         ch = got.chan;
         while (rdPos[ch] < expQ.size() && (expQ[rdPos[ch]].chan != ch ||
                (lossy && expQ[rdPos[ch]].timestamp < got.timestamp))) begin
            rdPos[ch]++;
         end
         if (rdPos[ch] >= expQ.size()) begin
            failRun($sformatf("record at index %0d matches no issued beat", i));
         end
         checkRec("rdRec", got, expQ[rdPos[ch]]);
         rdPos[ch]++;
      end
   endtask

   initial begin
      traceRecT rec;
      logic [NUM_CHAN-1:0] mask;
      logic [TOTAL_W-1:0] baseRec;
      logic [TOTAL_W-1:0] baseDrop;
      int beats;
      void'($urandom(SEED));

      // Sparse write requests
      resetDut();
      for (int b = 0; b < 12; b++) begin
         issueCycle(NUM_CHAN'(1) << CH_WRREQ);
         repeat ($urandom_range(3)) issueCycle('0);
      end
      issueCycle('0);
      waitDrain();
      checkCount("recTotal", recTotal, 12);
      checkCount("dropTotal", dropTotal, 0);
      checkCount("recCount", TOTAL_W'(recCount), 12);
      readBack(1'b0);
      readIndex(11, rec);
      checkChan("rdRec.chan", rec.chan, CH_WRREQ);

      // Sparse mix, capped below memory depth
      resetDut();
      beats = 0;
      repeat (24) begin
         mask = NUM_CHAN'($urandom) & NUM_CHAN'($urandom);
         if (beats + $countones(mask) > TRACE_DEPTH) begin
            mask = '0;
         end
         beats = beats + $countones(mask);
         issueCycle(mask);
      end
      issueCycle('0);
      waitDrain();
      checkCount("recTotal", recTotal, TOTAL_W'(beats));
      checkCount("dropTotal", dropTotal, 0);
      checkCount("recCount", TOTAL_W'(recCount), TOTAL_W'(beats));
      readBack(1'b0);

      // Wrap with 20 back to back read responses
      resetDut();
      repeat (20) issueCycle(NUM_CHAN'(1) << CH_RDRSP);
      issueCycle('0);
      waitDrain();
      checkCount("recCount", TOTAL_W'(recCount), TOTAL_W'(TRACE_DEPTH));
      checkCount("recTotal", recTotal, 20);
      readIndex(0, rec);
      checkChan("rdRec.chan", rec.chan, CH_RDRSP);
      // Fifth beat is the oldest survivor
      checkRec("rdRec", rec, expQ[4]);
      readBack(1'b1);

      // Overload, every channel every cycle
      resetDut();
      repeat (8) issueCycle('1);
      issueCycle('0);
      waitDrain();
      checkCount("recTotal+dropTotal", recTotal + dropTotal, TOTAL_W'(expQ.size()));
      readBack(1'b1);

      // Capture off, totals must hold
      @(negedge clk);
      baseRec = recTotal;
      baseDrop = dropTotal;
      @(posedge clk);
      enable <= 1'b0;
      repeat (10) issueCycle('1);
      repeat (DRAIN_SLACK) issueCycle('0);
      @(negedge clk);
      checkCount("recTotal", recTotal, baseRec);
      checkCount("dropTotal", dropTotal, baseDrop);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+bench
hw/ccipTracePkg.sv
hw/chanMonitor.sv
hw/traceArbiter.sv
hw/traceBuffer.sv
hw/ccipTraceTop.sv
bench/ccipTraceTb.sv

// File: Makefile
TOP := ccipTraceTb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		-f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
